/* include/uart_config.svh */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// bit time in clock cycles, timers count 0 .. UART_BIT_CYCLES-1
`define UART_BIT_CYCLES 10

// counter value used as the mid-bit sample point
`define UART_HALF_BIT 4

`define UART_DATA_BITS 8

// echo buffer entries, must be a power of two
`define UART_FIFO_DEPTH 4

`endif

/* rtl/uart_pkg.sv */
`include "uart_config.svh"

package uart_pkg;

    // ------------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------------
    typedef logic [`UART_DATA_BITS-1:0] byte_t;
    typedef logic [3:0]  bit_cnt_t;                           // bit index inside a frame
    typedef logic [15:0] timer_t;                             // bit-time counter
    typedef logic [$clog2(`UART_FIFO_DEPTH):0] fifo_ptr_t;    // extra msb tells full from empty

    // ------------------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_DONE
    } rx_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_LAUNCH, CTRL_SEND} ctrl_state_e;

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx_i,
    output uart_pkg::byte_t data_o,
    output logic            rx_done_o,
    output logic            frame_err_o
);

    localparam uart_pkg::timer_t   BIT_LAST  = uart_pkg::timer_t'(`UART_BIT_CYCLES - 1);
    localparam uart_pkg::timer_t   HALF_BIT  = uart_pkg::timer_t'(`UART_HALF_BIT);
    localparam uart_pkg::bit_cnt_t DATA_LAST = uart_pkg::bit_cnt_t'(`UART_DATA_BITS - 1);

    uart_pkg::rx_state_e state;
    uart_pkg::timer_t    cnt;
    uart_pkg::bit_cnt_t  bit_idx;
    uart_pkg::byte_t     shift_q;
    logic [3:0]          sync_q;        // [3] is the oldest sample
    logic                rx_s;
    logic                start_flag;
    logic                mid_bit;
    logic                stop_ok;

    // ------------------------------------------------------------------------
    // input synchronizer and start edge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 4'b1111;          // line idles high
        end else begin
            sync_q <= {sync_q[2:0], rx_i};
        end
    end

    assign rx_s       = sync_q[1];
    assign start_flag = sync_q[3] & sync_q[2] & ~sync_q[1] & ~sync_q[0];   // 1100 = falling edge

    // bit timer only runs while a frame is in progress
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if ((state == uart_pkg::RX_IDLE) || (cnt == BIT_LAST)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 16'd1;
        end
    end

    assign mid_bit = (cnt == HALF_BIT);

    // ------------------------------------------------------------------------
    // frame state machine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= uart_pkg::RX_IDLE;
            bit_idx     <= '0;
            stop_ok     <= 1'b0;
            rx_done_o   <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_done_o   <= 1'b0;        // strobes last one cycle
            frame_err_o <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    bit_idx <= '0;
                    if (start_flag) state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    if (mid_bit) begin
                        // a start that is high again at mid-bit was only a glitch
                        state <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (mid_bit) begin
                        bit_idx <= bit_idx + 4'd1;
                        if (bit_idx == DATA_LAST) state <= uart_pkg::RX_STOP;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (mid_bit) begin
                        stop_ok <= rx_s;
                        state   <= uart_pkg::RX_DONE;
                    end
                end
                uart_pkg::RX_DONE: begin
                    rx_done_o   <= stop_ok;
                    frame_err_o <= ~stop_ok;    // bad stop bit, byte is dropped
                    state       <= uart_pkg::RX_IDLE;
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // byte assembly, lsb arrives first and ends up at bit 0
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::RX_DATA) && mid_bit) begin
            shift_q <= {rx_s, shift_q[`UART_DATA_BITS-1:1]};
        end
        if ((state == uart_pkg::RX_DONE) && stop_ok) begin
            data_o <= shift_q;
        end
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tx_start_i,
    input  uart_pkg::byte_t tx_data_i,
    output logic            tx_o,
    output logic            tx_busy_o
);

    localparam uart_pkg::timer_t   BIT_LAST  = uart_pkg::timer_t'(`UART_BIT_CYCLES - 1);
    localparam uart_pkg::bit_cnt_t DATA_LAST = uart_pkg::bit_cnt_t'(`UART_DATA_BITS - 1);

    uart_pkg::tx_state_e state;
    uart_pkg::timer_t    cnt;
    uart_pkg::bit_cnt_t  bit_idx;
    uart_pkg::byte_t     shift_q;
    logic                bit_end;
    logic                load;
    logic                shift_en;

    assign bit_end   = (cnt == BIT_LAST);
    assign load      = (state == uart_pkg::TX_IDLE) && tx_start_i;
    // next data bit goes out at the end of start or of every data bit but the last
    assign shift_en  = bit_end && ((state == uart_pkg::TX_START) ||
                       ((state == uart_pkg::TX_DATA) && (bit_idx != DATA_LAST)));
    assign tx_busy_o = (state != uart_pkg::TX_IDLE);

    // bit timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if ((state == uart_pkg::TX_IDLE) || bit_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 16'd1;
        end
    end

    // ------------------------------------------------------------------------
    // frame sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    tx_o <= 1'b1;
                    if (tx_start_i) begin
                        tx_o  <= 1'b0;          // start bit
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        tx_o    <= shift_q[0];
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == DATA_LAST) begin
                            tx_o  <= 1'b1;      // stop bit
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            tx_o    <= shift_q[0];
                            bit_idx <= bit_idx + 4'd1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) state <= uart_pkg::TX_IDLE;
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // payload shift register, bit 0 is always the next bit to send
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data_i;
        end else if (shift_en) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

/* rtl/uart_fifo.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push_i,
    input  logic            pop_i,
    input  uart_pkg::byte_t push_data_i,
    output uart_pkg::byte_t head_data_o,
    output logic            empty_o,
    output logic            overflow_o
);

    localparam int AW = $clog2(`UART_FIFO_DEPTH);

    uart_pkg::byte_t   mem [`UART_FIFO_DEPTH];
    uart_pkg::fifo_ptr_t wr_ptr;
    uart_pkg::fifo_ptr_t rd_ptr;
    logic              full;
    logic              do_push;
    logic              do_pop;

    // ------------------------------------------------------------------------
    // status
    // ------------------------------------------------------------------------
    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push    = push_i && !full;
    assign do_pop     = pop_i && !empty_o;
    assign overflow_o = push_i && full;     // byte is dropped this cycle

    // first word fall through
    assign head_data_o = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + uart_pkg::fifo_ptr_t'(1);
            if (do_pop)  rd_ptr <= rd_ptr + uart_pkg::fifo_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

endmodule

/* rtl/uart_echo_ctrl.sv */
`timescale 1ns/1ps

module uart_echo_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            empty_i,
    input  logic            tx_pause_i,
    input  logic            tx_busy_i,
    input  uart_pkg::byte_t head_data_i,
    output logic            pop_o,
    output logic            tx_start_o,
    output uart_pkg::byte_t tx_data_o
);

    uart_pkg::ctrl_state_e state;
    logic                  launch;

    // partner holds tx_pause_i high to keep new frames back, like cts
    assign launch = (state == uart_pkg::CTRL_IDLE) && !empty_i && !tx_pause_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= uart_pkg::CTRL_IDLE;
            pop_o      <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            pop_o      <= launch;
            tx_start_o <= launch;
            case (state)
                uart_pkg::CTRL_IDLE: begin
                    if (launch) state <= uart_pkg::CTRL_LAUNCH;
                end
                uart_pkg::CTRL_LAUNCH: begin
                    if (tx_busy_i) state <= uart_pkg::CTRL_SEND;   // frame has started
                end
                uart_pkg::CTRL_SEND: begin
                    if (!tx_busy_i) state <= uart_pkg::CTRL_IDLE;  // stop bit done
                end
                default: state <= uart_pkg::CTRL_IDLE;
            endcase
        end
    end

    // head byte is captured together with the start strobe
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_data_o <= head_data_i;
        end
    end

endmodule

/* rtl/uart_echo_top.sv */
`timescale 1ns/1ps

module uart_echo_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx_i,
    input  logic            tx_pause_i,
    output logic            tx_o,
    output logic            rx_valid_o,
    output logic            frame_err_o,
    output logic            overflow_o,
    output uart_pkg::byte_t rx_data_o
);

    uart_pkg::byte_t rx_byte;
    uart_pkg::byte_t head_data;
    uart_pkg::byte_t tx_data;
    logic            rx_done;
    logic            empty;
    logic            pop;
    logic            tx_start;
    logic            tx_busy;

    // received bytes are also reported outside
    assign rx_valid_o = rx_done;
    assign rx_data_o  = rx_byte;

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .data_o      (rx_byte),
        .rx_done_o   (rx_done),
        .frame_err_o (frame_err_o)
    );

    uart_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (rx_done),
        .pop_i       (pop),
        .push_data_i (rx_byte),
        .head_data_o (head_data),
        .empty_o     (empty),
        .overflow_o  (overflow_o)
    );

    uart_echo_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty_i     (empty),
        .tx_pause_i  (tx_pause_i),
        .tx_busy_i   (tx_busy),
        .head_data_i (head_data),
        .pop_o       (pop),
        .tx_start_o  (tx_start),
        .tx_data_o   (tx_data)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_i  (tx_start),
        .tx_data_i   (tx_data),
        .tx_o        (tx_o),
        .tx_busy_o   (tx_busy)
    );

endmodule

/* tests/tb_uart_echo.sv */
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_echo;

    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 400 + 1000;
    localparam int ECHOED         = 0;
    localparam int FRAME_ERR      = 1;
    localparam int OVERFLOW       = 2;

    logic            clk;
    logic            rst_n;
    logic            rx_i;
    logic            tx_pause_i;
    logic            tx_o;
    logic            rx_valid_o;
    logic            frame_err_o;
    logic            overflow_o;
    uart_pkg::byte_t rx_data_o;

    // stimulus table with one column per array
    string           t_name    [NUM_TESTS];
    uart_pkg::byte_t t_data    [NUM_TESTS];
    logic            t_stop    [NUM_TESTS];
    logic            t_pause   [NUM_TESTS];
    int              t_outcome [NUM_TESTS];

    uart_pkg::byte_t exp_bytes [$];         // echo order expected on tx_o
    string           exp_names [$];

    logic [31:0]     rng_state = 32'd55010;
    int              cycle_cnt = 0;
    int              value_errs = 0;
    int              other_errs = 0;
    int              valid_cnt = 0;
    int              ferr_cnt = 0;
    int              ovf_cnt = 0;
    int              tx_starts = 0;
    int              echo_seen = 0;
    uart_pkg::byte_t last_rx;

    uart_echo_top u_uart_echo_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .tx_pause_i  (tx_pause_i),
        .tx_o        (tx_o),
        .rx_valid_o  (rx_valid_o),
        .frame_err_o (frame_err_o),
        .overflow_o  (overflow_o),
        .rx_data_o   (rx_data_o)
    );

    always #5 clk = ~clk;

    // hard limit on the run length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic uart_pkg::byte_t random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    task automatic set_entry(input int idx, input string name, input uart_pkg::byte_t data,
                             input logic stop_bit, input logic pause, input int outcome);
        t_name[idx]    = name;
        t_data[idx]    = data;
        t_stop[idx]    = stop_bit;
        t_pause[idx]   = pause;
        t_outcome[idx] = outcome;
    endtask

    task automatic fill_table();
        set_entry(0,  "basic_a5",  8'hA5,         1'b1, 1'b0, ECHOED);
        set_entry(1,  "all_zero",  8'h00,         1'b1, 1'b0, ECHOED);
        set_entry(2,  "all_ones",  8'hFF,         1'b1, 1'b0, ECHOED);
        set_entry(3,  "walk_lsb",  8'h01,         1'b1, 1'b0, ECHOED);
        set_entry(4,  "walk_msb",  8'h80,         1'b1, 1'b0, ECHOED);
        set_entry(5,  "filler_0",  random_byte(), 1'b1, 1'b0, ECHOED);
        set_entry(6,  "bad_stop",  8'h3C,         1'b0, 1'b0, FRAME_ERR);
        set_entry(7,  "filler_1",  random_byte(), 1'b1, 1'b0, ECHOED);
        set_entry(8,  "paused_0",  random_byte(), 1'b1, 1'b1, ECHOED);
        set_entry(9,  "paused_1",  random_byte(), 1'b1, 1'b1, ECHOED);
        set_entry(10, "paused_2",  random_byte(), 1'b1, 1'b1, ECHOED);
        set_entry(11, "paused_3",  random_byte(), 1'b1, 1'b1, ECHOED);
        set_entry(12, "paused_ov", 8'h5A,         1'b1, 1'b1, OVERFLOW);
        set_entry(13, "resume",    8'h96,         1'b1, 1'b0, ECHOED);
        set_entry(14, "bad_stop2", 8'hF1,         1'b0, 1'b0, FRAME_ERR);
        set_entry(15, "filler_2",  random_byte(), 1'b1, 1'b0, ECHOED);
    endtask

    // one frame on rx_i lsb first and then two idle bit times
    task automatic drive_frame(input uart_pkg::byte_t data, input logic stop_bit);
        logic [`UART_DATA_BITS+1:0] frame;
        int b;
        frame = {stop_bit, data, 1'b0};
        for (b = 0; b < `UART_DATA_BITS + 2; b++) begin
            @(posedge clk);
            rx_i <= frame[b];
            repeat (`UART_BIT_CYCLES - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_i <= 1'b1;
        repeat (2 * `UART_BIT_CYCLES - 1) @(posedge clk);
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        if (exp != act) begin
            value_errs++;
            $display("FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_echo(input uart_pkg::byte_t got);
        uart_pkg::byte_t exp_b;
        string           exp_n;
        echo_seen++;
        if (exp_bytes.size() == 0) begin
            other_errs++;
            $display("an unexpected frame carrying %h appeared on tx_o", got);
        end else begin
            exp_b = exp_bytes.pop_front();
            exp_n = exp_names.pop_front();
            if (got !== exp_b) begin
                value_errs++;
                $display("FAILED %s echo: expected %h, actual %h", exp_n, exp_b, got);
            end
        end
    endtask

    // wait until every byte due so far has left tx_o and the line is idle
    task automatic wait_echo_drain(input int due);
        while (echo_seen < due) @(negedge clk);
        repeat (2 * `UART_BIT_CYCLES) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (rx_valid_o) begin
                valid_cnt++;
                last_rx = rx_data_o;
            end
            if (frame_err_o) ferr_cnt++;
            if (overflow_o)  ovf_cnt++;
        end
    end

    initial begin : serial_monitor
        logic            prev_tx;
        uart_pkg::byte_t got;
        int              b;
        wait (rst_n === 1'b1);
        prev_tx = 1'b1;
        forever begin
            @(negedge clk);
            if (prev_tx && (tx_o === 1'b0)) begin
                tx_starts++;
                repeat (`UART_HALF_BIT) @(negedge clk);     // middle of the start bit
                if (tx_o !== 1'b0) begin
                    other_errs++;
                    $display("start bit on tx_o did not stay low until mid-bit");
                end
                for (b = 0; b < `UART_DATA_BITS; b++) begin
                    repeat (`UART_BIT_CYCLES) @(negedge clk);
                    got[b] = tx_o;
                end
                repeat (`UART_BIT_CYCLES) @(negedge clk);
                if (tx_o !== 1'b1) begin
                    other_errs++;
                    $display("stop bit on tx_o was not high");
                end
                check_echo(got);
            end
            prev_tx = tx_o;
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin : main_seq
        int i;
        int due;
        int starts_at_pause;
        int v0;
        int f0;
        int o0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        rx_i       = 1'b1;
        tx_pause_i = 1'b0;
        due        = 0;
        starts_at_pause = 0;

        fill_table();
        for (i = 0; i < NUM_TESTS; i++) begin
            if (t_outcome[i] == ECHOED) begin
                exp_bytes.push_back(t_data[i]);
                exp_names.push_back(t_name[i]);
            end
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // line idle and no strobes before the first frame
        repeat (10) begin
            @(negedge clk);
            if (tx_o !== 1'b1) begin
                value_errs++;
                $display("FAILED reset_state tx_o: expected 1, actual %b", tx_o);
            end
            if ({rx_valid_o, frame_err_o, overflow_o} !== 3'b000) begin
                value_errs++;
                $display("FAILED reset_state strobes: expected 000, actual %b",
                         {rx_valid_o, frame_err_o, overflow_o});
            end
        end

        for (i = 0; i < NUM_TESTS; i++) begin
            if (t_pause[i] && ((i == 0) || !t_pause[i-1])) begin
                wait_echo_drain(due);
                starts_at_pause = tx_starts;
            end
            if (!t_pause[i] && (i > 0) && t_pause[i-1]) begin
                if (tx_starts != starts_at_pause) begin
                    other_errs++;
                    $display("tx_o started %0d frames while tx_pause_i was high",
                             tx_starts - starts_at_pause);
                end
            end
            @(posedge clk);
            tx_pause_i <= t_pause[i];
            v0 = valid_cnt;
            f0 = ferr_cnt;
            o0 = ovf_cnt;
            drive_frame(t_data[i], t_stop[i]);

            check_count(t_name[i], "rx_valid_o pulses", (t_outcome[i] != FRAME_ERR) ? 1 : 0,
                        valid_cnt - v0);
            check_count(t_name[i], "frame_err_o pulses", (t_outcome[i] == FRAME_ERR) ? 1 : 0,
                        ferr_cnt - f0);
            check_count(t_name[i], "overflow_o pulses", (t_outcome[i] == OVERFLOW) ? 1 : 0,
                        ovf_cnt - o0);
            if ((t_outcome[i] != FRAME_ERR) && (valid_cnt - v0 == 1) &&
                (last_rx !== t_data[i])) begin
                value_errs++;
                $display("FAILED %s rx_data_o: expected %h, actual %h",
                         t_name[i], t_data[i], last_rx);
            end
            if (t_outcome[i] == ECHOED) due++;
        end

        wait_echo_drain(due);
        repeat (12 * `UART_BIT_CYCLES) @(negedge clk);   // room for a stray extra frame
        check_count("final", "frames on tx_o", due, tx_starts);
        if (exp_bytes.size() != 0) begin
            other_errs++;
            $display("%0d expected bytes never appeared on tx_o", exp_bytes.size());
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if ((value_errs == 0) && (other_errs == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_fifo.sv
rtl/uart_echo_ctrl.sv
rtl/uart_echo_top.sv
tests/tb_uart_echo.sv

/* Bender.yml */
package:
  name: uart_echo

export_include_dirs:
  - include

sources:
  - files:
      - rtl/uart_pkg.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/uart_fifo.sv
      - rtl/uart_echo_ctrl.sv
      - rtl/uart_echo_top.sv
  - target: test
    files:
      - tests/tb_uart_echo.sv
